/* flist.f */
+incdir+design
+incdir+sim
design/fdc_pkg.sv
design/fdc_cpu_port.sv
design/fdc_cmd_seq.sv
design/fdc_drive_regs.sv
design/fdc_disk_link.sv
design/fdc_result_buf.sv
design/fdc_top.sv
sim/tb_fdc.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fdc testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_fdc -f flist.f -Mdir obj_dir -o tb_fdc_sim

output=$(./obj_dir/tb_fdc_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -qxF "=== PASS ==="; then
  exit 0
else
  echo "simulation did not pass"
  exit 1
fi

/* sim/tb_fdc_tasks.svh */
// stop the run at the first failure
task automatic report_failure(input string msg);
  error_count++;
  $display("%s", msg);
  $display("=== FAIL ===");
  $fatal(1, "run stopped at first error");
endtask

task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    report_failure($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
  end
endtask

// lcg, numerical recipes constants
function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// bus tasks start and end on a falling edge
task automatic cpu_write(input logic addr, input logic mctl, input logic [7:0] data);
  ce       = 1'b1;
  a0       = addr;
  motorctl = mctl;
  din      = data;
  wr_n     = 1'b0;
  repeat (2) @(negedge clk);
  // din held while the strobe is consumed
  wr_n = 1'b1;
  repeat (2) @(negedge clk);
  ce       = 1'b0;
  motorctl = 1'b0;
endtask

task automatic cpu_read(input logic addr, output logic [7:0] data);
  ce   = 1'b1;
  a0   = addr;
  rd_n = 1'b0;
  repeat (2) @(negedge clk);
  data = dout;
  rd_n = 1'b1;
  // read completes on the rising rd_n
  repeat (2) @(negedge clk);
  ce = 1'b0;
endtask

task automatic expect_msr(input logic [7:0] exp);
  logic [7:0] b;
  cpu_read(1'b0, b);
  check_eq("msr", 32'(b), 32'(exp));
endtask

task automatic expect_data(input string name, input logic [7:0] exp);
  logic [7:0] b;
  cpu_read(1'b1, b);
  check_eq(name, 32'(b), 32'(exp));
endtask

// wait for one disk_sr bit to reach a level
task automatic wait_for(input int pos, input logic level, input string what);
  int n;
  n = 0;
  while (disk_sr[pos] !== level && n < 100) begin
    @(negedge clk);
    n++;
  end
  if (disk_sr[pos] !== level) begin
    report_failure($sformatf("%s did not happen within 100 cycles", what));
  end
endtask

// disk model for seek, seekdone until the request drops
task automatic finish_seek(input logic d, input logic err);
  wait_for(`FDC_SR_SEEK0 + int'(d), 1'b1, "seek request");
  disk_cr.error       = err;
  disk_cr.seekdone[d] = 1'b1;
  wait_for(`FDC_SR_SEEK0 + int'(d), 1'b0, "seek completion");
  disk_cr.seekdone = 2'b00;
  disk_cr.error    = 1'b0;
endtask

// disk model for read id, head and sector come with done
task automatic finish_read_id(input logic d, input logic [7:0] hd, input logic [7:0] sec,
                              input logic err, input logic wp);
  wait_for(`FDC_SR_READID0 + int'(d), 1'b1, "read id request");
  disk_cr.head     = hd;
  disk_cr.sector   = sec;
  disk_cr.error    = err;
  disk_cr.wp_error = wp;
  disk_cr.done     = 1'b1;
  wait_for(`FDC_SR_READID0 + int'(d), 1'b0, "read id completion");
  disk_cr.done     = 1'b0;
  disk_cr.error    = 1'b0;
  disk_cr.wp_error = 1'b0;
endtask

task automatic sense_int(input logic [7:0] exp_st0, input logic [7:0] exp_cyl,
                         input logic two_bytes);
  cpu_write(1'b1, 1'b0, 8'h08);
  // result phase, rfm dio busy
  expect_msr(8'hd0);
  expect_data("sense st0", exp_st0);
  if (two_bytes) begin
    expect_data("sense cylinder", exp_cyl);
  end
endtask

task automatic test_reset_specify();
  expect_msr(8'h80);
  check_eq("disk_sr", 32'(disk_sr), 32'h0);
  cpu_write(1'b1, 1'b0, 8'h03);
  // waiting for parameters
  expect_msr(8'h90);
  cpu_write(1'b1, 1'b0, 8'hdf);
  cpu_write(1'b1, 1'b0, 8'h02);
  expect_msr(8'h80);
  check_eq("disk_sr", 32'(disk_sr), 32'h0);
endtask

task automatic test_invalid_opcode();
  cpu_write(1'b1, 1'b0, 8'h1f);
  expect_msr(8'hd0);
  expect_data("invalid st0", 8'h80);
  expect_msr(8'h80);
endtask

task automatic test_seek(input logic d);
  logic [31:0] rnd;
  logic [7:0]  cyl;
  logic        hd;
  logic [7:0]  exp_st0;
  rnd = lcg_next();
  // nonzero target keeps track0 clear for this drive
  cyl = 8'(rnd[31:24] % 8'd79) + 8'd1;
  hd  = rnd[17];
  disk_cr.diskin = rnd[9:8];
  cpu_write(1'b1, 1'b0, 8'h0f);
  cpu_write(1'b1, 1'b0, {5'd0, hd, 1'b0, d});
  cpu_write(1'b1, 1'b0, cyl);
  check_eq("disk_sr.seek", 32'(disk_sr.seek), 32'(2'b01 << d));
  check_eq("disk_sr.cyl", 32'(disk_sr.cyl), 32'(cyl[6:0]));
  // only the drive busy bit, rfm low
  expect_msr(8'(8'h01 << d));
  finish_seek(d, 1'b0);
  check_eq("disk_sr.ack", 32'(disk_sr.ack), 32'h1);
  check_eq("disk_sr.seek", 32'(disk_sr.seek), 32'h0);
  expect_msr(8'h80);
  cyl_model[d] = cyl;
  exp_st0 = 8'h20 | 8'(d) | (disk_cr.diskin[d] ? 8'h00 : 8'h08);
  sense_int(exp_st0, cyl, 1'b1);
  // nothing pending any more
  sense_int(8'h80, 8'h00, 1'b0);
  expect_msr(8'h80);
endtask

task automatic test_recal_error(input logic d);
  logic [7:0] exp_st0;
  cpu_write(1'b1, 1'b0, 8'h07);
  cpu_write(1'b1, 1'b0, {7'd0, d});
  check_eq("disk_sr.seek", 32'(disk_sr.seek), 32'(2'b01 << d));
  check_eq("disk_sr.cyl", 32'(disk_sr.cyl), 32'h0);
  check_eq("disk_sr.ack", 32'(disk_sr.ack), 32'h0);
  finish_seek(d, 1'b1);
  cyl_model[d] = 8'd0;
  exp_st0 = 8'h40 | 8'(d) | (disk_cr.diskin[d] ? 8'h00 : 8'h08);
  sense_int(exp_st0, 8'h00, 1'b1);
  expect_msr(8'h80);
endtask

task automatic sense_drive_status(input logic d, input logic hd, input logic motor);
  logic       ready;
  logic [7:0] exp;
  ready = motor & disk_cr.diskin[d];
  exp = (disk_wp[d] ? 8'h40 : 8'h00) | (ready ? 8'h20 : 8'h00) |
        (cyl_model[d] == 8'd0 ? 8'h10 : 8'h00) | (hd ? 8'h04 : 8'h00) | 8'(d);
  cpu_write(1'b1, 1'b0, 8'h04);
  cpu_write(1'b1, 1'b0, {5'd0, hd, 1'b0, d});
  expect_msr(8'hd0);
  expect_data("st3", exp);
  expect_msr(8'h80);
endtask

task automatic test_sense_drive();
  disk_wp        = 2'b10;
  disk_cr.diskin = 2'b01;
  // motor still off after reset
  sense_drive_status(1'b0, 1'b1, 1'b0);
  sense_drive_status(1'b1, 1'b0, 1'b0);
  cpu_write(1'b0, 1'b1, 8'h01);
  sense_drive_status(1'b0, 1'b0, 1'b1);
  sense_drive_status(1'b1, 1'b1, 1'b1);
endtask

task automatic read_id_once(input logic err);
  logic [31:0] rnd;
  logic        d;
  logic        hd;
  logic        wp;
  logic [7:0]  head_val;
  logic [7:0]  sec_val;
  logic [7:0]  exp [7];
  rnd = lcg_next();
  d        = rnd[16];
  hd       = rnd[18];
  wp       = rnd[19];
  head_val = rnd[31:24];
  sec_val  = rnd[15:8];
  disk_cr.diskin = rnd[21:20];
  cpu_write(1'b1, 1'b0, 8'h0a);
  cpu_write(1'b1, 1'b0, {5'd0, hd, 1'b0, d});
  // exec phase while the disk side works
  expect_msr(8'h30);
  check_eq("disk_sr.readid", 32'(disk_sr.readid), 32'(2'b01 << d));
  check_eq("disk_sr.hs", 32'(disk_sr.hs), 32'(hd));
  finish_read_id(d, head_val, sec_val, err, wp);
  check_eq("disk_sr.ack", 32'(disk_sr.ack), 32'h1);
  exp[0] = (err ? 8'h40 : 8'h00) | (disk_cr.diskin[d] ? 8'h00 : 8'h08) |
           (hd ? 8'h04 : 8'h00) | 8'(d);
  exp[1] = (err ? 8'h25 : 8'h00) | (wp ? 8'h02 : 8'h00);
  exp[2] = err ? 8'h01 : 8'h00;
  exp[3] = cyl_model[d];
  exp[4] = head_val;
  exp[5] = sec_val;
  exp[6] = 8'd2;
  expect_msr(8'hd0);
  for (int i = 0; i < 7; i++) begin
    expect_data($sformatf("read id byte %0d", i), exp[i]);
  end
  expect_msr(8'h80);
endtask

/* sim/tb_fdc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fdc_params.svh"

module tb_fdc;

  localparam int CLK_PERIOD = 4;
  localparam int NUM_TESTS = 6;
  // 200 cycles per test, some slack for reset
  localparam int LIMIT_CYCLES = NUM_TESTS * 200 + 100;

  logic       clk;
  logic       rst_n;
  logic [7:0] din;
  logic [7:0] dout;
  logic       ce;
  logic       a0;
  logic       rd_n;
  logic       wr_n;
  logic       motorctl;
  logic [1:0] disk_wp;
  fdc_pkg::fdc_disk_resp_t disk_cr;
  fdc_pkg::fdc_disk_req_t  disk_sr;

  // reference state kept by the testbench
  logic [7:0] cyl_model [2];
  logic [31:0] lcg_state;
  int error_count;

  fdc_top i_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .din      (din),
    .dout     (dout),
    .ce       (ce),
    .a0       (a0),
    .rd_n     (rd_n),
    .wr_n     (wr_n),
    .motorctl (motorctl),
    .disk_wp  (disk_wp),
    .disk_cr  (disk_cr),
    .disk_sr  (disk_sr)
  );

  `include "tb_fdc_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // watchdog, whole run must fit in the cycle budget
  initial begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    report_failure($sformatf("timeout, tests did not finish within %0d cycles",
                             LIMIT_CYCLES));
  end

  initial begin
    logic [31:0] rnd;
    logic        first_drive;
    // all inputs idle, bus released
    rst_n       = 1'b0;
    din         = 8'h00;
    ce          = 1'b0;
    a0          = 1'b0;
    rd_n        = 1'b1;
    wr_n        = 1'b1;
    motorctl    = 1'b0;
    disk_wp     = 2'b00;
    disk_cr     = '0;
    cyl_model[0] = 8'd0;
    cyl_model[1] = 8'd0;
    lcg_state   = 32'h404b_ba24;
    error_count = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    test_reset_specify();
    test_invalid_opcode();
    rnd = lcg_next();
    first_drive = rnd[20];
    test_seek(first_drive);
    // recal on the other drive so one cylinder stays nonzero
    test_recal_error(~first_drive);
    test_sense_drive();
    read_id_once(1'b0);
    read_id_once(1'b1);

    if (error_count == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      report_failure("checks failed during the run");
    end
  end

endmodule

`default_nettype wire

/* design/fdc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fdc_top (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire [7:0]                    din,
  output logic [7:0]                   dout,
  input  wire                          ce,
  input  wire                          a0,
  input  wire                          rd_n,
  input  wire                          wr_n,
  input  wire                          motorctl,
  input  wire [1:0]                    disk_wp,
  input  wire fdc_pkg::fdc_disk_resp_t disk_cr,
  output fdc_pkg::fdc_disk_req_t       disk_sr
);

  fdc_pkg::fdc_bus_strobe_t  strobe;
  fdc_pkg::fdc_phase_e       phase;
  fdc_pkg::fdc_seek_cmd_t    seek_cmd;
  fdc_pkg::fdc_disk_event_t  evt;
  fdc_pkg::fdc_drive_state_t drv;
  fdc_pkg::fdc_result_load_t res_load;
  logic [7:0] pend_st0;
  logic [7:0] pend_st1;
  logic [7:0] result_byte;
  logic [1:0] pend_clr;
  logic       readid_req;
  logic       sel_drive;
  logic       sel_head;
  logic       last_read;

  // bus edges and status register
  fdc_cpu_port u_cpu_port (
    .clk         (clk),
    .rst_n       (rst_n),
    .ce          (ce),
    .a0          (a0),
    .rd_n        (rd_n),
    .wr_n        (wr_n),
    .motorctl    (motorctl),
    .phase       (phase),
    .seek_busy   (drv.busy),
    .result_byte (result_byte),
    .strobe      (strobe),
    .dout        (dout)
  );

  fdc_cmd_seq u_cmd_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .din        (din),
    .disk_wp    (disk_wp),
    .diskin     (disk_cr.diskin),
    .wp_error   (disk_cr.wp_error),
    .strobe     (strobe),
    .drv        (drv),
    .pend_st0   (pend_st0),
    .pend_st1   (pend_st1),
    .evt        (evt),
    .last_read  (last_read),
    .phase      (phase),
    .seek_cmd   (seek_cmd),
    .readid_req (readid_req),
    .sel_drive  (sel_drive),
    .sel_head   (sel_head),
    .pend_clr   (pend_clr),
    .res_load   (res_load)
  );

  // motor bit is din bit 0 on the control port
  fdc_drive_regs u_drive_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .seek_cmd  (seek_cmd),
    .evt       (evt),
    .motor_wr  (strobe.motor_wr),
    .motor_bit (din[0]),
    .pend_clr  (pend_clr),
    .drv       (drv),
    .pend_st0  (pend_st0),
    .pend_st1  (pend_st1)
  );

  fdc_disk_link u_disk_link (
    .clk        (clk),
    .rst_n      (rst_n),
    .seek_cmd   (seek_cmd),
    .readid_req (readid_req),
    .sel_drive  (sel_drive),
    .sel_head   (sel_head),
    .disk_cr    (disk_cr),
    .disk_sr    (disk_sr),
    .evt        (evt)
  );

  fdc_result_buf u_result_buf (
    .clk          (clk),
    .rst_n        (rst_n),
    .res_load     (res_load),
    .data_rd_done (strobe.data_rd_done),
    .result_byte  (result_byte),
    .last_read    (last_read)
  );

endmodule

`default_nettype wire

/* design/fdc_result_buf.sv */
`timescale 1ns/1ps
`default_nettype none

module fdc_result_buf (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire fdc_pkg::fdc_result_load_t res_load,
  input  wire                            data_rd_done,
  output logic [7:0]                     result_byte,
  output logic                           last_read
);

  logic [7:0] bytes_q [7];
  logic [2:0] len_q;
  logic [2:0] ptr_q;

  always_ff @(posedge clk) begin
    if (res_load.load) begin
      bytes_q[0] <= res_load.b0;
      bytes_q[1] <= res_load.b1;
      bytes_q[2] <= res_load.b2;
      bytes_q[3] <= res_load.b3;
      bytes_q[4] <= res_load.b4;
      bytes_q[5] <= res_load.b5;
      bytes_q[6] <= res_load.b6;
    end
  end

  // final byte consumed, buffer goes empty
  assign last_read = data_rd_done && len_q != 3'd0 && (ptr_q + 3'd1) == len_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      len_q <= 3'd0;
      ptr_q <= 3'd0;
    end else if (res_load.load) begin
      len_q <= res_load.len;
      ptr_q <= 3'd0;
    end else if (last_read) begin
      len_q <= 3'd0;
      ptr_q <= 3'd0;
    end else if (data_rd_done) begin
      ptr_q <= ptr_q + 3'd1;
    end
  end

  assign result_byte = bytes_q[ptr_q];

  // reads only complete in the result phase, which always has bytes
  a_no_empty_read : assert property (@(posedge clk) disable iff (!rst_n)
    data_rd_done |-> len_q != 3'd0);

endmodule

`default_nettype wire

/* design/fdc_disk_link.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fdc_params.svh"

module fdc_disk_link (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire fdc_pkg::fdc_seek_cmd_t  seek_cmd,
  input  wire                          readid_req,
  input  wire                          sel_drive,
  input  wire                          sel_head,
  input  wire fdc_pkg::fdc_disk_resp_t disk_cr,
  output fdc_pkg::fdc_disk_req_t       disk_sr,
  output fdc_pkg::fdc_disk_event_t     evt
);

  fdc_pkg::fdc_disk_req_t sr_q;
  logic seek_hit;
  logic id_hit;

  // completion only counts for the drive being served
  assign seek_hit = (disk_cr.seekdone & sr_q.seek) != 2'b00;
  assign id_hit   = (sr_q.readid != 2'b00) && disk_cr.done;

  // event pulse lasts until the request bits drop
  always_comb begin
    evt            = '0;
    evt.seek_done  = seek_hit;
    evt.seek_drive = sr_q.seek[1];
    evt.id_done    = id_hit;
    evt.error      = disk_cr.error;
    evt.head       = disk_cr.head;
    evt.sector     = disk_cr.sector;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sr_q <= '0;
    end else if (seek_cmd.start) begin
      // one hot per drive, ack drops with a new request
      sr_q.seek <= seek_cmd.drive ? 2'b10 : 2'b01;
      sr_q.cyl  <= seek_cmd.cylinder[6:0];
      sr_q.ack  <= 1'b0;
    end else if (readid_req) begin
      sr_q.readid <= sel_drive ? 2'b10 : 2'b01;
      sr_q.hs     <= sel_head;
      sr_q.ack    <= 1'b0;
    end else if (seek_hit) begin
      sr_q.seek <= 2'b00;
      sr_q.ack  <= 1'b1;
    end else if (id_hit) begin
      sr_q.readid <= 2'b00;
      sr_q.ack    <= 1'b1;
    end
  end

  assign disk_sr = sr_q;

  // the disk side serves one kind of request at a time
  a_one_request : assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({|disk_sr[`FDC_SR_SEEK1:`FDC_SR_SEEK0],
              |disk_sr[`FDC_SR_READID1:`FDC_SR_READID0],
              |disk_sr[`FDC_SR_WRITE1:`FDC_SR_WRITE0],
              |disk_sr[`FDC_SR_READSECT1:`FDC_SR_READSECT0]}));

endmodule

`default_nettype wire

/* design/fdc_drive_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module fdc_drive_regs (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire fdc_pkg::fdc_seek_cmd_t   seek_cmd,
  input  wire fdc_pkg::fdc_disk_event_t evt,
  input  wire                           motor_wr,
  input  wire                           motor_bit,
  input  wire [1:0]                     pend_clr,
  output fdc_pkg::fdc_drive_state_t     drv,
  output logic [7:0]                    pend_st0,
  output logic [7:0]                    pend_st1
);

  logic [7:0] cyl_q [2];
  logic [7:0] pend_q [2];
  logic [1:0] busy_q;
  logic       motor_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cyl_q[0]  <= 8'd0;
      cyl_q[1]  <= 8'd0;
      pend_q[0] <= 8'd0;
      pend_q[1] <= 8'd0;
      busy_q    <= 2'b00;
      motor_q   <= 1'b0;
    end else begin
      // motor latch from the control port
      if (motor_wr) begin
        motor_q <= motor_bit;
      end
      for (int d = 0; d < 2; d++) begin
        // seek end, 8'h20 or 8'h40 with the drive number
        if (evt.seek_done && evt.seek_drive == 1'(d)) begin
          busy_q[d] <= 1'b0;
          pend_q[d] <= {1'b0, evt.error, ~evt.error, 4'd0, 1'(d)};
        end else if (pend_clr[d]) begin
          // consumed by sense interrupt status
          pend_q[d] <= 8'd0;
        end
        // new seek target is taken at once
        if (seek_cmd.start && seek_cmd.drive == 1'(d)) begin
          busy_q[d] <= 1'b1;
          cyl_q[d]  <= seek_cmd.cylinder;
        end
      end
    end
  end

  assign drv      = {cyl_q[0], cyl_q[1], busy_q, motor_q};
  assign pend_st0 = pend_q[0];
  assign pend_st1 = pend_q[1];

endmodule

`default_nettype wire

/* design/fdc_cmd_seq.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fdc_params.svh"

module fdc_cmd_seq (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire [7:0]                      din,
  input  wire [1:0]                      disk_wp,
  input  wire [1:0]                      diskin,
  input  wire                            wp_error,
  input  wire fdc_pkg::fdc_bus_strobe_t  strobe,
  input  wire fdc_pkg::fdc_drive_state_t drv,
  input  wire [7:0]                      pend_st0,
  input  wire [7:0]                      pend_st1,
  input  wire fdc_pkg::fdc_disk_event_t  evt,
  input  wire                            last_read,
  output fdc_pkg::fdc_phase_e            phase,
  output fdc_pkg::fdc_seek_cmd_t         seek_cmd,
  output logic                           readid_req,
  output logic                           sel_drive,
  output logic                           sel_head,
  output logic [1:0]                     pend_clr,
  output fdc_pkg::fdc_result_load_t      res_load
);

  fdc_pkg::fdc_phase_e phase_q;
  fdc_pkg::fdc_phase_e phase_d;
  logic [4:0] op_q;
  logic [3:0] pcount_q;
  logic [3:0] need;
  logic       last_param;
  // drive and head from the first parameter byte
  logic       drive_q;
  logic       head_q;
  logic [7:0] cyl_cur;
  logic [7:0] cyl_id;
  logic       err;

  // seek and specify take two parameters, the rest one
  always_comb begin
    case (op_q)
      `FDC_OP_SEEK:    need = `FDC_PARAMS_SEEK;
      `FDC_OP_SPECIFY: need = `FDC_PARAMS_SPECIFY;
      default:         need = `FDC_PARAMS_ONE;
    endcase
  end

  assign last_param = (pcount_q + 4'd1) == need;
  // first parameter is still on din
  assign sel_drive = (pcount_q == 4'd0) ? din[0] : drive_q;
  assign sel_head  = (pcount_q == 4'd0) ? din[2] : head_q;
  assign cyl_cur   = sel_drive ? drv.cyl1 : drv.cyl0;
  assign cyl_id    = drive_q ? drv.cyl1 : drv.cyl0;
  assign err       = evt.error;
  assign phase     = phase_q;

  always_comb begin
    phase_d    = phase_q;
    seek_cmd   = '0;
    readid_req = 1'b0;
    pend_clr   = 2'b00;
    res_load   = '0;
    case (phase_q)
      fdc_pkg::ph_idle: begin
        if (strobe.data_wr) begin
          // flag bits are ignored
          case (din[4:0])
            `FDC_OP_SEEK, `FDC_OP_RECAL, `FDC_OP_SENSE_DRV,
            `FDC_OP_SPECIFY, `FDC_OP_READ_ID: begin
              phase_d = fdc_pkg::ph_cmd;
            end
            `FDC_OP_SENSE_INT: begin
              phase_d       = fdc_pkg::ph_result;
              res_load.load = 1'b1;
              // drive 0 first, bit 3 is not ready
              if (pend_st0 != 8'h00) begin
                res_load.len = `FDC_RES_LEN_SENSE;
                res_load.b0  = {pend_st0[7:4], ~diskin[0], pend_st0[2:0]};
                res_load.b1  = drv.cyl0;
                pend_clr     = 2'b01;
              end else if (pend_st1 != 8'h00) begin
                res_load.len = `FDC_RES_LEN_SENSE;
                res_load.b0  = {pend_st1[7:4], ~diskin[1], pend_st1[2:0]};
                res_load.b1  = drv.cyl1;
                pend_clr     = 2'b10;
              end else begin
                res_load.len = `FDC_RES_LEN_ONE;
                res_load.b0  = `FDC_INVALID_ST0;
              end
            end
            default: begin
              // unknown or dropped opcode
              phase_d       = fdc_pkg::ph_result;
              res_load.load = 1'b1;
              res_load.len  = `FDC_RES_LEN_ONE;
              res_load.b0   = `FDC_INVALID_ST0;
            end
          endcase
        end
      end
      fdc_pkg::ph_cmd: begin
        if (strobe.data_wr && last_param) begin
          case (op_q)
            `FDC_OP_SEEK, `FDC_OP_RECAL: begin
              // seek runs in the background
              seek_cmd.start    = 1'b1;
              seek_cmd.drive    = sel_drive;
              seek_cmd.cylinder = (op_q == `FDC_OP_SEEK) ? din : 8'd0;
              phase_d           = fdc_pkg::ph_idle;
            end
            `FDC_OP_SENSE_DRV: begin
              // st3 with wp, ready, track0, head, drive
              phase_d       = fdc_pkg::ph_result;
              res_load.load = 1'b1;
              res_load.len  = `FDC_RES_LEN_ONE;
              res_load.b0   = {1'b0, disk_wp[sel_drive], drv.motor_on & diskin[sel_drive],
                               cyl_cur == 8'd0, 1'b0, sel_head, 1'b0, sel_drive};
            end
            `FDC_OP_READ_ID: begin
              readid_req = 1'b1;
              phase_d    = fdc_pkg::ph_exec;
            end
            default: begin
              // specify, timings not modelled
              phase_d = fdc_pkg::ph_idle;
            end
          endcase
        end
      end
      fdc_pkg::ph_exec: begin
        // only read id waits here, data writes are dropped
        if (evt.id_done) begin
          phase_d       = fdc_pkg::ph_result;
          res_load.load = 1'b1;
          res_load.len  = `FDC_RES_LEN_ID;
          res_load.b0   = {1'b0, err, 2'b00, ~diskin[drive_q], head_q, 1'b0, drive_q};
          res_load.b1   = {2'b00, err, 2'b00, err, wp_error, err};
          res_load.b2   = {7'd0, err};
          res_load.b3   = cyl_id;
          res_load.b4   = evt.head;
          res_load.b5   = evt.sector;
          res_load.b6   = `FDC_SECTOR_SIZE_N;
        end
      end
      default: begin
        if (last_read) begin
          phase_d = fdc_pkg::ph_idle;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase_q  <= fdc_pkg::ph_idle;
      pcount_q <= 4'd0;
    end else begin
      phase_q <= phase_d;
      if (phase_q == fdc_pkg::ph_idle && strobe.data_wr) begin
        pcount_q <= 4'd0;
      end else if (phase_q == fdc_pkg::ph_cmd && strobe.data_wr) begin
        pcount_q <= pcount_q + 4'd1;
      end
    end
  end

  // opcode and selects are plain data
  always_ff @(posedge clk) begin
    if (phase_q == fdc_pkg::ph_idle && strobe.data_wr) begin
      op_q <= din[4:0];
    end
    if (phase_q == fdc_pkg::ph_cmd && strobe.data_wr && pcount_q == 4'd0) begin
      drive_q <= din[0];
      head_q  <= din[2];
    end
  end

endmodule

`default_nettype wire

/* design/fdc_cpu_port.sv */
`timescale 1ns/1ps
`default_nettype none

module fdc_cpu_port (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      ce,
  input  wire                      a0,
  input  wire                      rd_n,
  input  wire                      wr_n,
  input  wire                      motorctl,
  input  wire fdc_pkg::fdc_phase_e phase,
  input  wire [1:0]                seek_busy,
  input  wire [7:0]                result_byte,
  output fdc_pkg::fdc_bus_strobe_t strobe,
  output logic [7:0]               dout
);

  logic rd_q;
  logic wr_q;
  // a data read that started in the result phase
  logic rd_open;
  logic rd_fall;
  logic rd_rise;
  logic wr_fall;
  logic rfm;
  logic [7:0] msr;

  assign rd_fall = rd_q && !rd_n;
  assign rd_rise = !rd_q && rd_n;
  assign wr_fall = wr_q && !wr_n;

  // edges seen now, strobes come out next cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_q    <= 1'b1;
      wr_q    <= 1'b1;
      rd_open <= 1'b0;
      strobe  <= '0;
    end else begin
      rd_q <= rd_n;
      wr_q <= wr_n;
      strobe.data_wr      <= wr_fall && ce && a0 && !motorctl;
      strobe.motor_wr     <= wr_fall && motorctl;
      strobe.data_rd_done <= rd_rise && rd_open;
      if (rd_fall) begin
        rd_open <= ce && a0 && (phase == fdc_pkg::ph_result);
      end else if (rd_rise) begin
        rd_open <= 1'b0;
      end
    end
  end

  // ready for master, blocked in idle while any drive seeks
  assign rfm = (phase == fdc_pkg::ph_idle && seek_busy == 2'b00) ||
               phase == fdc_pkg::ph_cmd ||
               phase == fdc_pkg::ph_result;

  // rfm, dio, exm, busy, two zeros, drive busy
  assign msr = {rfm,
                phase == fdc_pkg::ph_result,
                phase == fdc_pkg::ph_exec,
                phase != fdc_pkg::ph_idle,
                2'b00,
                seek_busy};

  always_comb begin
    if (!ce || rd_n) begin
      dout = 8'hff;
    end else if (!a0) begin
      dout = msr;
    end else if (phase == fdc_pkg::ph_result) begin
      dout = result_byte;
    end else begin
      // no data phase here
      dout = 8'hff;
    end
  end

endmodule

`default_nettype wire

/* design/fdc_pkg.sv */
`default_nettype none

package fdc_pkg;

  // controller phase as seen by the cpu
  typedef enum logic [1:0] {
    ph_idle,
    ph_cmd,
    ph_exec,
    ph_result
  } fdc_phase_e;

  // single cycle pulses from the bus edge detector
  typedef struct packed {
    logic data_wr;
    logic motor_wr;
    logic data_rd_done;
  } fdc_bus_strobe_t;

  // disk_sr, request word towards the disk image side
  typedef struct packed {
    logic [1:0] seek;
    logic [1:0] readid;
    // write and readsect stay zero
    logic [1:0] write;
    logic [1:0] readsect;
    logic       ack;
    logic       hs;
    logic [6:0] head;
    logic [6:0] cyl;
    logic [7:0] sector;
  } fdc_disk_req_t;

  // disk_cr, completion word from the disk image side
  typedef struct packed {
    logic [7:0] sector;
    logic [7:0] pad_hi;
    logic [7:0] head;
    logic       pad_lo;
    logic [1:0] diskin;
    logic       done;
    logic       error;
    logic       wp_error;
    logic [1:0] seekdone;
  } fdc_disk_resp_t;

  // seek start, recalibrate sends cylinder 0
  typedef struct packed {
    logic       start;
    logic       drive;
    logic [7:0] cylinder;
  } fdc_seek_cmd_t;

  // completion pulses with values taken from disk_cr
  typedef struct packed {
    logic       seek_done;
    logic       seek_drive;
    logic       id_done;
    logic       error;
    logic [7:0] head;
    logic [7:0] sector;
  } fdc_disk_event_t;

  typedef struct packed {
    logic [7:0] cyl0;
    logic [7:0] cyl1;
    logic [1:0] busy;
    logic       motor_on;
  } fdc_drive_state_t;

  // result bytes loaded in one go, b0 is read first
  typedef struct packed {
    logic       load;
    logic [2:0] len;
    logic [7:0] b0;
    logic [7:0] b1;
    logic [7:0] b2;
    logic [7:0] b3;
    logic [7:0] b4;
    logic [7:0] b5;
    logic [7:0] b6;
  } fdc_result_load_t;

endpackage

`default_nettype wire

/* design/fdc_params.svh */
`ifndef FDC_PARAMS_SVH
`define FDC_PARAMS_SVH

// command opcodes, low five bits of the command byte
`define FDC_OP_SPECIFY      5'h03
`define FDC_OP_SENSE_DRV    5'h04
`define FDC_OP_RECAL        5'h07
`define FDC_OP_SENSE_INT    5'h08
`define FDC_OP_READ_ID      5'h0a
`define FDC_OP_SEEK         5'h0f

// parameter bytes expected after the command byte
`define FDC_PARAMS_SEEK     4'd2
`define FDC_PARAMS_SPECIFY  4'd2
`define FDC_PARAMS_ONE      4'd1

// result phase lengths
`define FDC_RES_LEN_ID      3'd7
`define FDC_RES_LEN_SENSE   3'd2
`define FDC_RES_LEN_ONE     3'd1

// st0 for an invalid opcode or an empty sense
`define FDC_INVALID_ST0     8'h80
// n code of a 512 byte sector
`define FDC_SECTOR_SIZE_N   8'd2

// request pair positions in disk_sr
`define FDC_SR_SEEK1        31
`define FDC_SR_SEEK0        30
`define FDC_SR_READID1      29
`define FDC_SR_READID0      28
`define FDC_SR_WRITE1       27
`define FDC_SR_WRITE0       26
`define FDC_SR_READSECT1    25
`define FDC_SR_READSECT0    24

`endif
